// File: Makefile
# Verilator build and run for the rename core testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= rename_core_tb
FILELIST  ?= rename_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
FAIL_MSG  ?= TEST RESULT: FAIL
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ended without a result line, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rename_ref_model.svh
//////////////////////////////////////////////////////////////////////
// reference model of the rename and retire core
// mappings, ready bits, free queue, rob order and the cdb register
//////////////////////////////////////////////////////////////////////

`ifndef RENAME_REF_MODEL_SVH
`define RENAME_REF_MODEL_SVH

// arch register state
phys_reg_t m_map [`NUM_ARCH_REG];
bit        m_ready [`NUM_ARCH_REG];
// free tags, next dest tag at the front
phys_reg_t m_free [$];
// rob entries, oldest at index 0
arch_reg_t m_rob_arch [$];
phys_reg_t m_rob_new [$];
phys_reg_t m_rob_old [$];
bit        m_rob_done [$];
int        m_rob_tail;
// bus as it stands this cycle
bit        m_cdb_valid;
phys_reg_t m_cdb_tag;

function automatic void model_reset();
  m_free.delete();
  m_rob_arch.delete();
  m_rob_new.delete();
  m_rob_old.delete();
  m_rob_done.delete();
  for (int i = 0; i < `NUM_ARCH_REG; i++) begin
    m_map[i]   = phys_reg_t'(i);
    m_ready[i] = 1'b1;
  end
  for (int i = `NUM_ARCH_REG; i < `NUM_PHYS_REG; i++) begin
    m_free.push_back(phys_reg_t'(i));
  end
  m_rob_tail  = 0;
  m_cdb_valid = 1'b0;
  m_cdb_tag   = '0;
endfunction

// a rob slot and a free tag
function automatic bit model_dispatch_ready();
  return (m_rob_new.size() < `ROB_SIZE) && (m_free.size() != 0);
endfunction

// stored ready bit or the tag on the bus right now
function automatic bit model_src_ready(arch_reg_t a);
  return m_ready[a] || (m_cdb_valid && (m_map[a] == m_cdb_tag));
endfunction

function automatic bit model_retire_valid();
  return (m_rob_done.size() != 0) && m_rob_done[0];
endfunction

// lowest requesting unit, zero when none
function automatic fu_mask_t model_grant(fu_mask_t req);
  for (int i = 0; i < `NUM_FU; i++) begin
    if (req[i]) return fu_mask_t'(1 << i);
  end
  return '0;
endfunction

// one clock edge, all decisions taken from the state before it
function automatic void model_step(bit disp_v, arch_reg_t d, phys_reg_t g_tag, bit g_any);
  bit fire;
  bit retire;
  fire   = disp_v && model_dispatch_ready();
  retire = model_retire_valid();
  if (m_cdb_valid) begin
    for (int i = 0; i < `NUM_ARCH_REG; i++) begin
      if (m_map[i] == m_cdb_tag) m_ready[i] = 1'b1;
    end
    for (int i = 0; i < m_rob_new.size(); i++) begin
      if (m_rob_new[i] == m_cdb_tag) m_rob_done[i] = 1'b1;
    end
  end
  // old tag of the retiring entry goes back to the pool
  if (retire) begin
    m_free.push_back(m_rob_old[0]);
    void'(m_rob_arch.pop_front());
    void'(m_rob_new.pop_front());
    void'(m_rob_old.pop_front());
    void'(m_rob_done.pop_front());
  end
  // rename overrides a same-edge wakeup
  if (fire) begin
    m_rob_arch.push_back(d);
    m_rob_new.push_back(m_free[0]);
    m_rob_old.push_back(m_map[d]);
    m_rob_done.push_back(1'b0);
    m_map[d]   = m_free.pop_front();
    m_ready[d] = 1'b0;
    m_rob_tail = (m_rob_tail + 1) % `ROB_SIZE;
  end
  m_cdb_valid = g_any;
  m_cdb_tag   = g_tag;
endfunction

`endif

// File: bench/rename_core_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the rename core
// random dispatch and completion checked against the reference model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module rename_core_tb import rename_pkg::*; ();

  localparam int CLOCK_PERIOD = 40;
  // reset plus the lengths of all tests below
  localparam int TOTAL_CYCLES = 3 + 6 + 300 + 150 + 80 + 300;

  logic      clock;
  logic      reset;
  logic      dispatch_valid;
  arch_reg_t dest_arch;
  arch_reg_t src_a_arch;
  arch_reg_t src_b_arch;
  logic      dispatch_ready;
  phys_reg_t src_a_tag;
  logic      src_a_ready;
  phys_reg_t src_b_tag;
  logic      src_b_ready;
  phys_reg_t dest_tag;
  phys_reg_t dest_old_tag;
  rob_idx_t  rob_tag;
  fu_mask_t  fu_valid;
  phys_reg_t fu_tag [`NUM_FU];
  fu_mask_t  fu_grant;
  logic      cdb_valid;
  phys_reg_t cdb_tag;
  logic      retire_valid;
  arch_reg_t retire_arch;
  phys_reg_t retire_tag;
  phys_reg_t retire_freed_tag;

  logic [31:0] lcg_state = 32'h99e7;
  int cycle;
  int checks;
  int test_errors;
  int total_errors;
  int tests_run;
  // dispatched tags not yet handed to a unit
  phys_reg_t pending [$];
  int grant_cycle [`NUM_PHYS_REG];

  `include "rename_ref_model.svh"

  rename_core rename_core_i (.*);

  initial begin
    clock = 1'b0;
    forever #(CLOCK_PERIOD / 2) clock = ~clock;
  end

  initial begin : watchdog
    #(CLOCK_PERIOD * (TOTAL_CYCLES + 50));
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // value in 0 to n-1 from the upper lcg bits
  function automatic int pick_below(int n);
    return int'(lcg_next() >> 16) % n;
  endfunction

  task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
    checks++;
    assert (actual === expected) else begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, actual, expected);
      test_errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // per-cycle compare at the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic check_outputs();
    check_value("dispatch_ready", 32'(dispatch_ready), 32'(model_dispatch_ready()));
    check_value("src_a_tag", 32'(src_a_tag), 32'(m_map[src_a_arch]));
    check_value("src_a_ready", 32'(src_a_ready), 32'(model_src_ready(src_a_arch)));
    check_value("src_b_tag", 32'(src_b_tag), 32'(m_map[src_b_arch]));
    check_value("src_b_ready", 32'(src_b_ready), 32'(model_src_ready(src_b_arch)));
    if (m_free.size() != 0) check_value("dest_tag", 32'(dest_tag), 32'(m_free[0]));
    check_value("dest_old_tag", 32'(dest_old_tag), 32'(m_map[dest_arch]));
    check_value("rob_tag", 32'(rob_tag), m_rob_tail);
    check_value("fu_grant", 32'(fu_grant), 32'(model_grant(fu_valid)));
    check_value("cdb_valid", 32'(cdb_valid), 32'(m_cdb_valid));
    if (m_cdb_valid) check_value("cdb_tag", 32'(cdb_tag), 32'(m_cdb_tag));
    check_value("retire_valid", 32'(retire_valid), 32'(model_retire_valid()));
    // head fields only mean something while retiring
    if (model_retire_valid()) begin
      check_value("retire_arch", 32'(retire_arch), 32'(m_rob_arch[0]));
      check_value("retire_tag", 32'(retire_tag), 32'(m_rob_new[0]));
      check_value("retire_freed_tag", 32'(retire_freed_tag), 32'(m_rob_old[0]));
    end
  endtask

  // a unit holds its tag until granted
  task automatic drive_inputs(int disp_pct, int offer_pct, fu_mask_t grant);
    int k;
    dispatch_valid <= (pick_below(100) < disp_pct);
    dest_arch      <= arch_reg_t'(pick_below(`NUM_ARCH_REG));
    src_a_arch     <= arch_reg_t'(pick_below(`NUM_ARCH_REG));
    src_b_arch     <= arch_reg_t'(pick_below(`NUM_ARCH_REG));
    for (int i = 0; i < `NUM_FU; i++) begin
      if (grant[i] || !fu_valid[i]) begin
        if ((pending.size() != 0) && (pick_below(100) < offer_pct)) begin
          k = pick_below(pending.size());
          fu_valid[i] <= 1'b1;
          fu_tag[i]   <= pending[k];
          pending.delete(k);
        end else begin
          fu_valid[i] <= 1'b0;
        end
      end
    end
  endtask

  task automatic clock_cycle(int disp_pct, int offer_pct);
    fu_mask_t  grant;
    phys_reg_t g_tag;
    @(negedge clock);
    check_outputs();
    grant = model_grant(fu_valid);
    g_tag = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (grant[i]) g_tag = fu_tag[i];
    end
    // bus cycle and completion edge lie between grant and retire
    if (retire_valid) begin
      checks++;
      assert (cycle - grant_cycle[retire_tag] >= 2) else begin
        $display("tag 0x%0h retired only %0d cycles after its grant", retire_tag,
                 cycle - grant_cycle[retire_tag]);
        test_errors++;
      end
    end
    if (grant != '0) grant_cycle[g_tag] = cycle;
    @(posedge clock);
    cycle++;
    if (dispatch_valid && model_dispatch_ready()) pending.push_back(m_free[0]);
    model_step(dispatch_valid, dest_arch, g_tag, grant != '0);
    drive_inputs(disp_pct, offer_pct, grant);
  endtask

  task automatic run_test(string name, int cycles, int disp_pct, int offer_pct);
    test_errors = 0;
    for (int c = 0; c < cycles; c++) clock_cycle(disp_pct, offer_pct);
    total_errors += test_errors;
    tests_run++;
    $display("test %s: %0d cycles, %0d errors", name, cycles, test_errors);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    dispatch_valid = 1'b0;
    dest_arch      = '0;
    src_a_arch     = '0;
    src_b_arch     = '0;
    fu_valid       = '0;
    for (int i = 0; i < `NUM_FU; i++) fu_tag[i] = '0;
    reset = 1'b1;
    model_reset();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    // identity map and initial free tags with no completions
    run_test("reset_state", 6, 100, 0);
    run_test("rename_wakeup", 300, 60, 50);
    // rob fills and dispatch stalls
    run_test("back_pressure", 150, 95, 10);
    run_test("drain", 80, 0, 100);
    run_test("fifo_reuse", 300, 70, 70);
    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, total_errors);
    if (total_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: common/rename_config.svh
//////////////////////////////////////////////////////////////////////
// sizing macros for the rename and retire core
// register counts, rob depth, completion ports
//////////////////////////////////////////////////////////////////////

`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural registers seen by the isa
`define NUM_ARCH_REG 32

// physical register file size
// must exceed NUM_ARCH_REG, the surplus is the free pool
`define NUM_PHYS_REG 48

// in-flight instruction window
`define ROB_SIZE 8

// functional units competing for the cdb
`define NUM_FU 4

// free pool depth, one slot per non-architectural tag
`define FREE_LIST_SIZE (`NUM_PHYS_REG - `NUM_ARCH_REG)

`endif

// File: common/rename_pkg.sv
//////////////////////////////////////////////////////////////////////
// shared vector types for the rename and retire core
//////////////////////////////////////////////////////////////////////

`include "rename_config.svh"

package rename_pkg;

  // architectural register index
  // 5 bits with the default sizing
  typedef logic [$clog2(`NUM_ARCH_REG)-1:0] arch_reg_t;

  // physical register tag
  // also the tag broadcast on the cdb
  typedef logic [$clog2(`NUM_PHYS_REG)-1:0] phys_reg_t;

  // rob slot index
  typedef logic [$clog2(`ROB_SIZE)-1:0] rob_idx_t;

  // one bit per functional unit
  // used for requests and grants
  typedef logic [`NUM_FU-1:0] fu_mask_t;

endpackage

// File: rename_core.f
+incdir+common
+incdir+bench
common/rename_pkg.sv
rtl/map_table.sv
rtl/free_list.sv
rtl/cdb_arbiter.sv
rob/rob.sv
rtl/rename_core.sv
bench/rename_core_tb.sv

// File: rob/rob.sv
//////////////////////////////////////////////////////////////////////
// reorder buffer
// allocation at the tail, cdb tag match, in-order retire at the head
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module rob import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // dispatch
  input  logic      alloc,
  input  arch_reg_t alloc_arch,
  input  phys_reg_t alloc_tag,
  input  phys_reg_t alloc_old_tag,
  // completion
  input  logic      cdb_valid,
  input  phys_reg_t cdb_tag,
  // occupancy
  output logic      full,
  output rob_idx_t  tail_idx,
  // retirement
  output logic      retire_valid,
  output arch_reg_t retire_arch,
  output phys_reg_t retire_tag,
  output phys_reg_t retire_freed_tag
);

  localparam int CNT_W = $clog2(`ROB_SIZE + 1);

  // per-entry status
  logic [`ROB_SIZE-1:0] valid_q;
  logic [`ROB_SIZE-1:0] complete_q;

  // per-entry payload
  arch_reg_t arch_q    [`ROB_SIZE];
  phys_reg_t new_tag_q [`ROB_SIZE];
  phys_reg_t old_tag_q [`ROB_SIZE];

  rob_idx_t         head_q;
  rob_idx_t         tail_q;
  logic [CNT_W-1:0] count_q;

  function automatic rob_idx_t next_idx(input rob_idx_t idx);
    return (idx == rob_idx_t'(`ROB_SIZE - 1)) ? '0 : idx + 1'b1;
  endfunction

  assign full     = (count_q == CNT_W'(`ROB_SIZE));
  assign tail_idx = tail_q;

  //////////////////////////////////////////////////////////////////////
  // head view
  //////////////////////////////////////////////////////////////////////

  // oldest entry leaves as soon as it is complete
  assign retire_valid     = valid_q[head_q] & complete_q[head_q];
  assign retire_arch      = arch_q[head_q];
  assign retire_tag       = new_tag_q[head_q];
  assign retire_freed_tag = old_tag_q[head_q];

  //////////////////////////////////////////////////////////////////////
  // status and pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q    <= '0;
      complete_q <= '0;
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
    end else begin
      // completion, match against every live entry
      if (cdb_valid) begin
        for (int i = 0; i < `ROB_SIZE; i++) begin
          if (valid_q[i] && (new_tag_q[i] == cdb_tag)) begin
            complete_q[i] <= 1'b1;
          end
        end
      end
      // retire the head
      if (retire_valid) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= next_idx(head_q);
      end
      // allocate at the tail
      // never the retiring slot, alloc implies not full
      if (alloc) begin
        valid_q[tail_q]    <= 1'b1;
        complete_q[tail_q] <= 1'b0;
        tail_q             <= next_idx(tail_q);
      end
      case ({alloc, retire_valid})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload written on allocation only
  always_ff @(posedge clock) begin
    if (alloc) begin
      arch_q[tail_q]    <= alloc_arch;
      new_tag_q[tail_q] <= alloc_tag;
      old_tag_q[tail_q] <= alloc_old_tag;
    end
  end

endmodule

// File: rtl/cdb_arbiter.sv
//////////////////////////////////////////////////////////////////////
// cdb arbiter with fixed priority grant and the cdb register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module cdb_arbiter import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // one request and tag per functional unit
  input  fu_mask_t  fu_valid,
  input  phys_reg_t fu_tag [`NUM_FU],
  output fu_mask_t  fu_grant,
  // registered broadcast
  output logic      cdb_valid,
  output phys_reg_t cdb_tag
);

  logic      grant_any;
  phys_reg_t grant_tag;

  // lowest index wins and at most one unit is granted
  always_comb begin
    fu_grant  = '0;
    grant_any = 1'b0;
    grant_tag = '0;
    for (int i = 0; i < `NUM_FU; i++) begin
      if (fu_valid[i] && !grant_any) begin
        fu_grant[i] = 1'b1;
        grant_any   = 1'b1;
        grant_tag   = fu_tag[i];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus register
  //////////////////////////////////////////////////////////////////////

  // granted tag goes out the cycle after the grant
  always_ff @(posedge clock) begin
    if (reset) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= grant_any;
    end
  end

  // bus tag follows the grant mux every cycle
  always_ff @(posedge clock) begin
    cdb_tag <= grant_tag;
  end

endmodule

// File: rtl/free_list.sv
//////////////////////////////////////////////////////////////////////
// free list of physical tags
// circular queue with head, tail and count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module free_list import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // take the head tag
  input  logic      pop,
  // return a tag at the tail
  input  logic      push,
  input  phys_reg_t push_tag,
  output phys_reg_t head_tag,
  output logic      empty
);

  localparam int DEPTH = `FREE_LIST_SIZE;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // queue storage
  phys_reg_t tags_q [DEPTH];

  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [CNT_W-1:0] count_q;

  // wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign head_tag = tags_q[head_q];
  assign empty    = (count_q == '0);

  //////////////////////////////////////////////////////////////////////
  // queue update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // starts full with the tags above the arch range
      // in ascending order
      for (int i = 0; i < DEPTH; i++) begin
        tags_q[i] <= phys_reg_t'(`NUM_ARCH_REG + i);
      end
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= CNT_W'(DEPTH);
    end else begin
      if (pop) begin
        head_q <= next_ptr(head_q);
      end
      if (push) begin
        tags_q[tail_q] <= push_tag;
        tail_q         <= next_ptr(tail_q);
      end
      // pop and push together leave the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: rtl/map_table.sv
//////////////////////////////////////////////////////////////////////
// map table, arch register to physical tag
// ready bits with cdb wakeup and same-cycle bypass
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module map_table import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // dispatch side
  input  logic      rename_en,
  input  arch_reg_t dest_arch,
  input  arch_reg_t src_a_arch,
  input  arch_reg_t src_b_arch,
  input  phys_reg_t dest_tag,
  // completion broadcast
  input  logic      cdb_valid,
  input  phys_reg_t cdb_tag,
  // lookups
  output phys_reg_t src_a_tag,
  output phys_reg_t src_b_tag,
  output phys_reg_t dest_old_tag,
  output logic      src_a_ready,
  output logic      src_b_ready
);

  // current mapping per arch register
  phys_reg_t tag_q [`NUM_ARCH_REG];
  // value already produced
  logic [`NUM_ARCH_REG-1:0] ready_q;

  //////////////////////////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////////////////////////

  // reads see the table before this cycle's own rename
  assign src_a_tag    = tag_q[src_a_arch];
  assign src_b_tag    = tag_q[src_b_arch];
  assign dest_old_tag = tag_q[dest_arch];

  // bypass, a tag on the cdb this cycle counts as ready
  assign src_a_ready = ready_q[src_a_arch] | (cdb_valid & (src_a_tag == cdb_tag));
  assign src_b_ready = ready_q[src_b_arch] | (cdb_valid & (src_b_tag == cdb_tag));

  //////////////////////////////////////////////////////////////////////
  // update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      // identity mapping, everything ready
      for (int i = 0; i < `NUM_ARCH_REG; i++) begin
        tag_q[i]   <= phys_reg_t'(i);
        ready_q[i] <= 1'b1;
      end
    end else begin
      // wakeup of whichever entry still maps the broadcast tag
      if (cdb_valid) begin
        for (int i = 0; i < `NUM_ARCH_REG; i++) begin
          if (tag_q[i] == cdb_tag) begin
            ready_q[i] <= 1'b1;
          end
        end
      end
      // new mapping, placed last so it beats a wakeup of the same entry
      if (rename_en) begin
        tag_q[dest_arch]   <= dest_tag;
        ready_q[dest_arch] <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/rename_core.sv
//////////////////////////////////////////////////////////////////////
// rename and retire core top level
// map table, free list, cdb arbiter, rob and dispatch stall
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

`include "rename_config.svh"

module rename_core import rename_pkg::*; (
  input  logic      clock,
  input  logic      reset,
  // dispatch
  input  logic      dispatch_valid,
  input  arch_reg_t dest_arch,
  input  arch_reg_t src_a_arch,
  input  arch_reg_t src_b_arch,
  output logic      dispatch_ready,
  output phys_reg_t src_a_tag,
  output logic      src_a_ready,
  output phys_reg_t src_b_tag,
  output logic      src_b_ready,
  output phys_reg_t dest_tag,
  output phys_reg_t dest_old_tag,
  output rob_idx_t  rob_tag,
  // functional units
  input  fu_mask_t  fu_valid,
  input  phys_reg_t fu_tag [`NUM_FU],
  output fu_mask_t  fu_grant,
  // cdb
  output logic      cdb_valid,
  output phys_reg_t cdb_tag,
  // retirement
  output logic      retire_valid,
  output arch_reg_t retire_arch,
  output phys_reg_t retire_tag,
  output phys_reg_t retire_freed_tag
);

  logic rob_full;
  logic fl_empty;
  logic dispatch_fire;

  //////////////////////////////////////////////////////////////////////
  // dispatch stall
  //////////////////////////////////////////////////////////////////////

  // needs a rob slot and a free tag
  assign dispatch_ready = ~rob_full & ~fl_empty;
  assign dispatch_fire  = dispatch_valid & dispatch_ready;

  map_table map_table_i (
    .clock        (clock),
    .reset        (reset),
    .rename_en    (dispatch_fire),
    .dest_arch    (dest_arch),
    .src_a_arch   (src_a_arch),
    .src_b_arch   (src_b_arch),
    .dest_tag     (dest_tag),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .src_a_tag    (src_a_tag),
    .src_b_tag    (src_b_tag),
    .dest_old_tag (dest_old_tag),
    .src_a_ready  (src_a_ready),
    .src_b_ready  (src_b_ready)
  );

  // retired old tags flow back into the pool
  free_list free_list_i (
    .clock    (clock),
    .reset    (reset),
    .pop      (dispatch_fire),
    .push     (retire_valid),
    .push_tag (retire_freed_tag),
    .head_tag (dest_tag),
    .empty    (fl_empty)
  );

  cdb_arbiter cdb_arbiter_i (
    .clock     (clock),
    .reset     (reset),
    .fu_valid  (fu_valid),
    .fu_tag    (fu_tag),
    .fu_grant  (fu_grant),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag)
  );

  rob rob_i (
    .clock            (clock),
    .reset            (reset),
    .alloc            (dispatch_fire),
    .alloc_arch       (dest_arch),
    .alloc_tag        (dest_tag),
    .alloc_old_tag    (dest_old_tag),
    .cdb_valid        (cdb_valid),
    .cdb_tag          (cdb_tag),
    .full             (rob_full),
    .tail_idx         (rob_tag),
    .retire_valid     (retire_valid),
    .retire_arch      (retire_arch),
    .retire_tag       (retire_tag),
    .retire_freed_tag (retire_freed_tag)
  );

endmodule
